// ==== rtl/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  localparam int xlen      = 32;
  localparam int reg_count = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // funct3 codes for the supported loads, stores and branches
  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sw  = 3'b010;
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;

  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen-1:0] data_t;
  typedef logic [xlen-1:0] instr_t;
  typedef logic [xlen-1:0] imm_t;

  typedef enum logic [6:0] {
    op_r      = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111,
    op_lui    = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [3:0] {
    st_fetch, st_decode, st_mem_adr, st_mem_read, st_mem_wb, st_mem_write,
    st_exec_r, st_exec_i, st_alu_wb, st_branch, st_jal, st_lui
  } state_e;

  typedef enum logic {adr_pc, adr_result} adr_src_e;
  typedef enum logic [1:0] {a_pc, a_old_pc, a_rs1, a_zero} alu_src_a_e;
  typedef enum logic [1:0] {b_rs2, b_imm, b_four} alu_src_b_e;
  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_e;
  typedef enum logic {pc_alu_result, pc_alu_out} pc_src_e;

  typedef struct packed {
    logic        pc_update;
    logic        ir_write;
    logic        reg_write;
    adr_src_e    adr_src;
    alu_src_a_e  alu_src_a;
    alu_src_b_e  alu_src_b;
    result_src_e result_src;
    pc_src_e     pc_src;
    logic        alu_use_decode; // 0 makes the ALU add
  } ctrl_t;

  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    imm_t       imm;
    alu_op_e    alu_op;
  } decoded_t;

  typedef struct packed {
    addr_t      address;
    data_t      write_data;
    logic [3:0] write_enable;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
  import riscv_pkg::*;
(
  input  data_t   a,
  input  data_t   b,
  input  alu_op_e op,
  output data_t   y,
  output logic    zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:  y = a + b;
      alu_sub:  y = a - b;
      alu_and:  y = a & b;
      alu_or:   y = a | b;
      alu_xor:  y = a ^ b;
      alu_slt:  y = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: y = {31'b0, a < b};
      alu_sll:  y = a << shamt;
      alu_srl:  y = a >> shamt;
      alu_sra:  y = $signed(a) >>> shamt;
      default:  y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== rtl/control_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_fsm
  import riscv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  decoded_t   decoded,
  input  logic       zero,
  input  logic [1:0] addr_low,
  output ctrl_t      ctrl,
  output logic [3:0] write_enable
);

  state_e state;
  state_e state_next;
  logic   started; // holds off the first fetch until one edge after reset
  logic   taken;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_fetch;
      started <= 1'b0;
    end else begin
      state   <= state_next;
      started <= 1'b1;
    end
  end

  assign taken = ((decoded.funct3 == f3_beq) && zero) ||
                 ((decoded.funct3 == f3_bne) && !zero);

  always_comb begin
    state_next = st_fetch;
    case (state)
      st_fetch:   state_next = started ? st_decode : st_fetch;
      st_decode: begin
        case (decoded.opcode)
          op_r:      state_next = st_exec_r;
          op_imm:    state_next = st_exec_i;
          op_load:   state_next = st_mem_adr;
          op_store:  state_next = st_mem_adr;
          op_branch: state_next = st_branch;
          op_jal:    state_next = st_jal;
          op_lui:    state_next = st_lui;
          default:   state_next = st_fetch; // unknown opcode retires with no writes
        endcase
      end
      st_mem_adr:  state_next = (decoded.opcode == op_load) ? st_mem_read : st_mem_write;
      st_mem_read: state_next = st_mem_wb;
      st_exec_r:   state_next = st_alu_wb;
      st_exec_i:   state_next = st_alu_wb;
      st_jal:      state_next = st_alu_wb;
      st_lui:      state_next = st_alu_wb;
      default:     state_next = st_fetch;
    endcase
  end

  always_comb begin
    ctrl            = '0;
    ctrl.adr_src    = adr_pc;
    ctrl.alu_src_a  = a_pc;
    ctrl.alu_src_b  = b_four;
    ctrl.result_src = res_alu_out;
    ctrl.pc_src     = pc_alu_result;
    case (state)
      st_fetch: begin
        ctrl.ir_write   = started;
        ctrl.pc_update  = started;
        ctrl.result_src = res_alu_result;
      end
      st_decode: begin // branch and jal targets land in alu_out here
        ctrl.alu_src_a = a_old_pc;
        ctrl.alu_src_b = b_imm;
      end
      st_mem_adr: begin
        ctrl.alu_src_a = a_rs1;
        ctrl.alu_src_b = b_imm;
      end
      st_mem_read:  ctrl.adr_src = adr_result;
      st_mem_write: ctrl.adr_src = adr_result;
      st_mem_wb: begin
        ctrl.result_src = res_data;
        ctrl.reg_write  = 1'b1;
      end
      st_exec_r: begin
        ctrl.alu_src_a      = a_rs1;
        ctrl.alu_src_b      = b_rs2;
        ctrl.alu_use_decode = 1'b1;
      end
      st_exec_i: begin
        ctrl.alu_src_a      = a_rs1;
        ctrl.alu_src_b      = b_imm;
        ctrl.alu_use_decode = 1'b1;
      end
      st_alu_wb: ctrl.reg_write = 1'b1;
      st_branch: begin
        ctrl.alu_src_a      = a_rs1;
        ctrl.alu_src_b      = b_rs2;
        ctrl.alu_use_decode = 1'b1; // decode hands out sub for branches
        ctrl.pc_src         = pc_alu_out;
        ctrl.pc_update      = taken;
      end
      st_jal: begin
        ctrl.alu_src_a = a_old_pc;
        ctrl.pc_src    = pc_alu_out;
        ctrl.pc_update = 1'b1;
      end
      st_lui: begin
        ctrl.alu_src_a = a_zero;
        ctrl.alu_src_b = b_imm;
      end
      default: ctrl.adr_src = adr_pc;
    endcase
  end

  // store byte lanes follow funct3 and the low address bits
  always_comb begin
    write_enable = 4'b0000;
    if (state == st_mem_write) begin
      case (decoded.funct3)
        f3_sw:   write_enable = 4'b1111;
        f3_sb:   write_enable = 4'b0001 << addr_low;
        default: write_enable = 4'b0000;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch
  import riscv_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    pc_update,
  input  logic    ir_write,
  input  pc_src_e pc_src,
  input  data_t   alu_result,
  input  data_t   alu_out,
  output addr_t   pc_cur,
  output addr_t   pc_old
);

  addr_t pc_next;

  assign pc_next = (pc_src == pc_alu_out) ? alu_out : alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_cur <= reset_pc;
      pc_old <= reset_pc;
    end else begin
      if (pc_update) pc_cur <= pc_next;
      if (ir_write)  pc_old <= pc_cur; // address of the instruction now in the IR
    end
  end

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decode
  import riscv_pkg::*;
(
  input  instr_t   instr,
  output decoded_t decoded
);

  logic [2:0] funct3;
  logic       funct7_b5;
  logic       is_shift;
  imm_t       imm;
  alu_op_e    alu_op;

  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];
  assign is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);

  assign decoded.opcode = opcode_e'(instr[6:0]);
  assign decoded.funct3 = funct3;
  assign decoded.rd     = instr[11:7];
  assign decoded.rs1    = instr[19:15];
  assign decoded.rs2    = instr[24:20];
  assign decoded.imm    = imm;
  assign decoded.alu_op = alu_op;

  always_comb begin
    case (decoded.opcode)
      op_imm:    imm = is_shift ? {27'b0, instr[24:20]}
                                : {{20{instr[31]}}, instr[31:20]};
      op_load:   imm = {{20{instr[31]}}, instr[31:20]};
      op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                        instr[11:8], 1'b0};
      op_jal:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                        instr[30:21], 1'b0};
      op_lui:    imm = {instr[31:12], 12'b0};
      default:   imm = '0;
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    if (decoded.opcode == op_r || decoded.opcode == op_imm) begin
      case (funct3)
        3'b000: alu_op = (decoded.opcode == op_r && funct7_b5) ? alu_sub : alu_add;
        3'b001: alu_op = alu_sll;
        3'b010: alu_op = alu_slt;
        3'b011: alu_op = alu_sltu;
        3'b100: alu_op = alu_xor;
        3'b101: alu_op = funct7_b5 ? alu_sra : alu_srl;
        3'b110: alu_op = alu_or;
        default: alu_op = alu_and;
      endcase
    end else if (decoded.opcode == op_branch) begin
      alu_op = alu_sub; // compare by subtraction
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mem_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_loader
  import riscv_pkg::*;
(
  input  data_t      rdata,
  input  logic [1:0] addr_low,
  input  logic [2:0] funct3,
  input  data_t      store_src,
  output data_t      load_data,
  output data_t      write_data
);

  logic [7:0] byte_sel;

  always_comb begin
    case (addr_low)
      2'd0:    byte_sel = rdata[7:0];
      2'd1:    byte_sel = rdata[15:8];
      2'd2:    byte_sel = rdata[23:16];
      default: byte_sel = rdata[31:24];
    endcase
  end

  always_comb begin
    case (funct3)
      f3_lb:   load_data = {{24{byte_sel[7]}}, byte_sel};
      f3_lbu:  load_data = {24'b0, byte_sel};
      f3_lw:   load_data = rdata;
      default: load_data = rdata;
    endcase
  end

  // the byte enable picks the lane, so sb just repeats the byte everywhere
  assign write_data = (funct3 == f3_sb) ? {4{store_src[7:0]}} : store_src;

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import riscv_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       we,
  input  logic [4:0] ra1,
  input  logic [4:0] ra2,
  input  logic [4:0] wa,
  input  data_t      wd,
  output data_t      rd1,
  output data_t      rd2
);

  data_t regs [reg_count];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 5'd0) begin
      regs[wa] <= wd; // x0 is never written, so it reads as zero
    end
  end

  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

endmodule

`default_nettype wire

// ==== rtl/riscv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_core
  import riscv_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  output mem_req_t mem_req,
  input  data_t    mem_rdata
);

  ctrl_t      ctrl;
  decoded_t   decoded;
  instr_t     instr;
  data_t      data;
  data_t      alu_out;
  data_t      opnd_a;
  data_t      opnd_b;
  data_t      rd1;
  data_t      rd2;
  addr_t      pc_cur;
  addr_t      pc_old;
  data_t      alu_a;
  data_t      alu_b;
  data_t      alu_result;
  data_t      result;
  alu_op_e    alu_op;
  logic       zero;
  addr_t      address;
  data_t      load_data;
  data_t      store_data;
  logic [3:0] write_enable;

  control_fsm u_control_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .decoded      (decoded),
    .zero         (zero),
    .addr_low     (address[1:0]),
    .ctrl         (ctrl),
    .write_enable (write_enable)
  );

  fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_update  (ctrl.pc_update),
    .ir_write   (ctrl.ir_write),
    .pc_src     (ctrl.pc_src),
    .alu_result (alu_result),
    .alu_out    (alu_out),
    .pc_cur     (pc_cur),
    .pc_old     (pc_old)
  );

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) instr <= mem_rdata;
    data    <= load_data;
    alu_out <= alu_result;
    opnd_a  <= rd1; // operands refresh every cycle and are used the cycle after decode
    opnd_b  <= rd2;
  end

  instr_decode u_instr_decode (
    .instr   (instr),
    .decoded (decoded)
  );

  reg_file u_reg_file (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (ctrl.reg_write),
    .ra1   (decoded.rs1),
    .ra2   (decoded.rs2),
    .wa    (decoded.rd),
    .wd    (result),
    .rd1   (rd1),
    .rd2   (rd2)
  );

  always_comb begin
    case (ctrl.alu_src_a)
      a_pc:     alu_a = pc_cur;
      a_old_pc: alu_a = pc_old;
      a_rs1:    alu_a = opnd_a;
      default:  alu_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      b_rs2:   alu_b = opnd_b;
      b_imm:   alu_b = decoded.imm;
      default: alu_b = 32'd4;
    endcase
  end

  assign alu_op = ctrl.alu_use_decode ? decoded.alu_op : alu_add;

  alu u_alu (
    .a    (alu_a),
    .b    (alu_b),
    .op   (alu_op),
    .y    (alu_result),
    .zero (zero)
  );

  always_comb begin
    case (ctrl.result_src)
      res_alu_out: result = alu_out;
      res_data:    result = data;
      default:     result = alu_result;
    endcase
  end

  assign address = (ctrl.adr_src == adr_result) ? result : pc_cur;

  mem_loader u_mem_loader (
    .rdata      (mem_rdata),
    .addr_low   (address[1:0]),
    .funct3     (decoded.funct3),
    .store_src  (opnd_b),
    .load_data  (load_data),
    .write_data (store_data)
  );

  assign mem_req = '{address: address, write_data: store_data, write_enable: write_enable};

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model
  import riscv_pkg::*;
(
  input  logic     clk,
  input  mem_req_t req,
  output data_t    rdata
);

  data_t      words [1024]; // 4 KB so the byte address wraps above bit 11
  logic [9:0] index;

  assign index = req.address[11:2];
  assign rdata = words[index]; // data follows the address with no wait states

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (req.write_enable[i]) begin
        words[index][8 * i +: 8] <= req.write_data[8 * i +: 8];
      end
    end
  end

  // preload one word while the core is held in reset
  task automatic load_word(input int unsigned word_index, input data_t value);
    words[word_index] <= value;
  endtask

endmodule

`default_nettype wire

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core
  import riscv_pkg::*;
();

  localparam int    clk_period = 100;
  localparam addr_t done_addr  = 32'h0000_0ffc;

  logic     clk;
  logic     rst_n;
  mem_req_t mem_req;
  data_t    mem_rdata;

  logic [31:0] lfsr;
  data_t       ref_mem [1024];
  data_t       ref_regs [32];
  addr_t       ref_pc;
  int          prog_len;
  int          instr_count;
  int          expected_total;
  int          stores_seen;
  int          mismatch_count;
  int          other_errors;
  logic        ref_ready;
  mem_req_t    expected_q [$];
  mem_req_t    exp_store;

  riscv_core u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

  tb_mem_model u_mem (
    .clk   (clk),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  always #(clk_period / 2) clk = ~clk;

  // galois form, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                    input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic instr_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                    input logic [2:0] f3, input logic [4:0] rd,
                                    input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic instr_t s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                    input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                    input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic instr_t u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic emit(input instr_t w);
    ref_mem[prog_len] = w;
    prog_len++;
  endtask

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    logic        equal;
    logic        use_bne;
    int          off;
    prog_len = 0;
    emit(i_type(12'h600, 5'd0, 3'b000, 5'd30, 7'b0010011)); // x30 points at the data area
    for (int r = 1; r <= 8; r++) begin
      emit(u_type(20'(rand_bits(20)), 5'(r)));
      emit(i_type(12'(rand_bits(12)), 5'(r), 3'b000, 5'(r), 7'b0010011));
    end
    for (int round = 0; round < 4; round++) begin
      for (int k = 0; k < 10; k++) begin
        rd  = (k == 0) ? 5'd0 : 5'(rand_bits(4) % 9);
        rs1 = 5'(rand_bits(4) % 9);
        rs2 = 5'(rand_bits(4) % 9);
        f3  = 3'(rand_bits(3));
        alt = rand_bits(1);
        if (rand_bits(1) == 1) begin
          emit(r_type((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                      rs2, rs1, f3, rd));
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {(alt && f3 == 3'b101) ? 7'h20 : 7'h00, 5'(rand_bits(5))};
          emit(i_type(imm, rs1, f3, rd, 7'b0010011));
        end else begin
          emit(i_type(12'(rand_bits(12)), rs1, f3, rd, 7'b0010011));
        end
      end
      for (int r = 0; r <= 8; r++) begin
        emit(s_type(12'(4 * r), 5'(r), 5'd30, 3'b010));
      end
    end
    for (int i = 0; i < 8; i++) begin
      imm    = 12'(rand_bits(12));
      imm[7] = i[0]; // alternate the sign of the stored byte
      off    = 256 + int'(rand_bits(6));
      emit(i_type(imm, 5'd0, 3'b000, 5'd11, 7'b0010011));
      emit(s_type(12'(off), 5'd11, 5'd30, 3'b000));
      emit(i_type(12'(off), 5'd30, 3'b000, 5'd9, 7'b0000011));
      emit(i_type(12'(off), 5'd30, 3'b100, 5'd10, 7'b0000011));
      emit(s_type(12'h040, 5'd9, 5'd30, 3'b010));
      emit(s_type(12'h044, 5'd10, 5'd30, 3'b010));
    end
    for (int i = 0; i < 8; i++) begin
      equal   = rand_bits(1);
      use_bne = rand_bits(1);
      emit(i_type(12'(rand_bits(11)), 5'd0, 3'b000, 5'd12, 7'b0010011));
      imm = equal ? 12'd0 : (12'(rand_bits(4)) | 12'd1);
      emit(i_type(imm, 5'd12, 3'b000, 5'd13, 7'b0010011));
      emit(b_type(13'd12, 5'd13, 5'd12, use_bne ? 3'b001 : 3'b000)); // taken skips one marker
      emit(i_type(12'(2 * i + 1), 5'd0, 3'b000, 5'd14, 7'b0010011));
      emit(s_type(12'h048, 5'd14, 5'd30, 3'b010));
      emit(i_type(12'(2 * i + 2), 5'd0, 3'b000, 5'd14, 7'b0010011));
      emit(s_type(12'h048, 5'd14, 5'd30, 3'b010));
    end
    emit(32'h0000_0000); // unknown opcode retires with no effect
    emit(i_type(12'h7ff, 5'd0, 3'b000, 5'd14, 7'b0010011));
    emit(j_type(21'd8, 5'd15));
    emit(s_type(12'h04c, 5'd14, 5'd30, 3'b010));
    emit(s_type(12'h050, 5'd15, 5'd30, 3'b010));
    emit(j_type(21'd12, 5'd15));
    emit(s_type(12'h04c, 5'd14, 5'd30, 3'b010));
    emit(s_type(12'h04c, 5'd14, 5'd30, 3'b010));
    emit(s_type(12'h050, 5'd15, 5'd30, 3'b010));
    for (int i = 0; i < 4; i++) begin
      emit(u_type(20'(rand_bits(20)), 5'd16));
      emit(i_type(12'(rand_bits(12)), 5'd16, 3'b000, 5'd16, 7'b0010011));
      emit(s_type(12'h054, 5'd16, 5'd30, 3'b010));
    end
    emit(u_type(20'h00001, 5'd29));
    emit(u_type(20'h600dd, 5'd28));
    emit(i_type(12'h0e5, 5'd28, 3'b000, 5'd28, 7'b0010011));
    emit(s_type(12'hffc, 5'd28, 5'd29, 3'b010)); // 0x1000 - 4 is the done address
    emit(j_type(21'd0, 5'd0));
  endtask

  // executes one instruction and returns any store it makes with a nonzero byte enable
  function automatic mem_req_t step_reference();
    instr_t     ins;
    data_t      a;
    data_t      b;
    data_t      res;
    data_t      word;
    addr_t      addr;
    addr_t      next_pc;
    logic       alt;
    logic       wr;
    logic [7:0] lane;
    mem_req_t   st;
    ins     = ref_mem[ref_pc[11:2]];
    a       = ref_regs[ins[19:15]];
    b       = ref_regs[ins[24:20]];
    alt     = ins[30] && (ins[5] || ins[14:12] == 3'b101);
    next_pc = ref_pc + 4;
    res     = '0;
    wr      = 1'b0;
    st      = '0;
    case (ins[6:0])
      7'b0110011, 7'b0010011: begin
        if (!ins[5]) b = {{20{ins[31]}}, ins[31:20]};
        wr = 1'b1;
        case (ins[14:12])
          3'b000: res = alt ? a - b : a + b;
          3'b001: res = a << b[4:0];
          3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: res = (a < b) ? 32'd1 : 32'd0;
          3'b100: res = a ^ b;
          3'b101: begin
            if (alt) res = $signed(a) >>> b[4:0];
            else res = a >> b[4:0];
          end
          3'b110: res = a | b;
          default: res = a & b;
        endcase
      end
      7'b0000011: begin
        addr = a + {{20{ins[31]}}, ins[31:20]};
        word = ref_mem[addr[11:2]];
        lane = word[8 * addr[1:0] +: 8];
        wr   = 1'b1;
        case (ins[14:12])
          3'b000: res = {{24{lane[7]}}, lane};
          3'b100: res = {24'b0, lane};
          default: res = word;
        endcase
      end
      7'b0100011: begin
        st.address = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        if (ins[14:12] == 3'b000) begin
          st.write_enable = 4'b0001 << st.address[1:0];
          st.write_data   = {4{b[7:0]}};
        end else begin
          st.write_enable = 4'b1111;
          st.write_data   = b;
        end
        for (int i = 0; i < 4; i++) begin
          if (st.write_enable[i]) begin
            ref_mem[st.address[11:2]][8 * i +: 8] = st.write_data[8 * i +: 8];
          end
        end
      end
      7'b1100011: begin
        if ((a == b) != ins[12]) begin // bne sets funct3 bit 0
          next_pc = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        res     = ref_pc + 4;
        wr      = 1'b1;
        next_pc = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      7'b0110111: begin
        res = {ins[31:12], 12'b0};
        wr  = 1'b1;
      end
      default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = res;
    ref_pc = next_pc;
    return st;
  endfunction

  task automatic run_reference();
    mem_req_t st;
    logic     reached;
    ref_pc      = reset_pc;
    instr_count = 0;
    reached     = 1'b0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    while (!reached && instr_count < 5000) begin
      st = step_reference();
      instr_count++;
      if (st.write_enable != 4'b0000) begin
        expected_q.push_back(st);
        reached = (st.address == done_addr);
      end
    end
    expected_total = expected_q.size();
    if (!reached) begin
      other_errors++;
      $display("reference model never reached the done store");
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d mismatches, %0d other; stores seen %0d of %0d",
             mismatch_count, other_errors, stores_seen, expected_total);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    lfsr           = 32'h59ba_f012;
    ref_ready      = 1'b0;
    stores_seen    = 0;
    mismatch_count = 0;
    other_errors   = 0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = {~i[15:0], i[15:0]};
    end
    build_program();
    @(posedge clk);
    #10;
    for (int i = 0; i < 1024; i++) begin
      u_mem.load_word(i, ref_mem[i]);
    end
    run_reference();
    ref_ready = 1'b1;
    repeat (3) @(posedge clk);
    #10 rst_n = 1'b1;
  end

  // every instruction takes at most five cycles
  initial begin
    wait (ref_ready);
    #(instr_count * 5 * clk_period + 50 * clk_period);
    other_errors++;
    $display("timeout: done store not seen after %0d reference instructions", instr_count);
    finish_run();
  end

  always @(posedge clk) begin
    if (mem_req.write_enable != 4'b0000) begin
      if (!rst_n) begin
        other_errors++;
        $display("write enable active during reset at %0t", $time);
      end else if (expected_q.size() == 0) begin
        other_errors++;
        $display("unexpected write to address %h at %0t", mem_req.address, $time);
      end else begin
        exp_store = expected_q.pop_front();
        stores_seen++;
        check_value("mem_req.address", mem_req.address, exp_store.address);
        check_value("mem_req.write_data", mem_req.write_data, exp_store.write_data);
        check_value("mem_req.write_enable", {28'b0, mem_req.write_enable},
                    {28'b0, exp_store.write_enable});
        if (expected_q.size() == 0 || mem_req.address == done_addr) begin
          if (stores_seen != expected_total) begin
            other_errors++;
            $display("done store came with %0d expected stores still missing",
                     expected_total - stores_seen);
          end
          finish_run();
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== riscv_core.f ====
rtl/riscv_pkg.sv
rtl/alu.sv
rtl/control_fsm.sv
rtl/fetch.sv
rtl/instr_decode.sv
rtl/mem_loader.sv
rtl/reg_file.sv
rtl/riscv_core.sv
test/tb_mem_model.sv
test/tb_riscv_core.sv
